// ==== verilog/window_geom_pkg.sv ====
package window_geom_pkg;

  // Pixel word width of the stream
  localparam int DEF_DATA_WIDTH = 16;

  // Image size before the pad border is added
  localparam int DEF_IMG_WIDTH = 5;
  localparam int DEF_IMG_HEIGHT = 4;

  // Channels are interleaved innermost in the raster stream
  localparam int DEF_CHANNELS = 2;

  // Kernel footprint that each emitted window covers
  localparam int DEF_KERNEL_WIDTH = 3;
  localparam int DEF_KERNEL_HEIGHT = 3;

  // Border width added on every side of the image
  localparam int DEF_PAD = 1;

  // Largest stride the register block accepts
  localparam int DEF_MAX_STRIDE = 3;

  // Width of every x, y and channel coordinate.
  // It must hold the padded width and height and the channel count
  localparam int COORD_WIDTH = 8;

endpackage

// ==== verilog/window_cfg_pkg.sv ====
package window_cfg_pkg;

  // Register map of the configuration block
  typedef enum logic [1:0] {
    CFG_STRIDE    = 2'd0,
    CFG_PAD_VALUE = 2'd1
  } cfg_addr_e;

  // Width of the stride field
  localparam int STRIDE_WIDTH = 4;

  // Values after reset
  localparam int RESET_STRIDE = 1;
  localparam int RESET_PAD_VALUE = 0;

endpackage

// ==== verilog/window_cfg_regs.sv ====
module window_cfg_regs
  import window_cfg_pkg::*;
#(
  parameter int DATA_WIDTH = 16,
  parameter int MAX_STRIDE = 3
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    cfg_wr,
  input  cfg_addr_e               cfg_addr,
  input  logic [DATA_WIDTH-1:0]   cfg_wdata,
  output logic [DATA_WIDTH-1:0]   cfg_rdata,
  output logic [STRIDE_WIDTH-1:0] stride,
  output logic [DATA_WIDTH-1:0]   pad_value
);

  logic [STRIDE_WIDTH-1:0] stride_wr;

  // Clamp the written stride into the range 1 to MAX_STRIDE
  always_comb begin
    if (cfg_wdata == '0) begin
      stride_wr = STRIDE_WIDTH'(1);
    end else if (cfg_wdata > MAX_STRIDE) begin
      stride_wr = STRIDE_WIDTH'(MAX_STRIDE);
    end else begin
      stride_wr = cfg_wdata[STRIDE_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stride    <= STRIDE_WIDTH'(RESET_STRIDE);
      pad_value <= DATA_WIDTH'(RESET_PAD_VALUE);
    end else if (cfg_wr) begin
      case (cfg_addr)
        CFG_STRIDE:    stride <= stride_wr;
        CFG_PAD_VALUE: pad_value <= cfg_wdata;
        default:       ;
      endcase
    end
  end

  // Readback follows the address in the same cycle
  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      CFG_STRIDE:    cfg_rdata[STRIDE_WIDTH-1:0] = stride;
      CFG_PAD_VALUE: cfg_rdata = pad_value;
      default:       cfg_rdata = '0;
    endcase
  end

endmodule

// ==== verilog/window_padder.sv ====
module window_padder
  import window_geom_pkg::*;
#(
  parameter int DATA_WIDTH = 16,
  parameter int IMG_WIDTH  = 5,
  parameter int IMG_HEIGHT = 4,
  parameter int CHANNELS   = 2,
  parameter int PAD        = 1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [DATA_WIDTH-1:0] pix_data,
  input  logic                  pix_valid,
  output logic                  pix_ready,
  output logic [DATA_WIDTH-1:0] pad_data,
  output logic                  pad_valid,
  input  logic                  pad_ready,
  input  logic [DATA_WIDTH-1:0] pad_value
);

  localparam int PADDED_WIDTH = IMG_WIDTH + 2 * PAD;
  localparam int PADDED_HEIGHT = IMG_HEIGHT + 2 * PAD;

  typedef enum logic {
    PAD_BORDER,
    PAD_IMAGE
  } pad_state_e;

  pad_state_e state;

  // Position of the next output word in the padded frame
  logic [COORD_WIDTH-1:0] row, col, ch;
  logic [COORD_WIDTH-1:0] row_next, col_next, ch_next;
  logic next_in_image;
  logic out_fire;

  assign out_fire = pad_valid && pad_ready;

  always_comb begin
    ch_next  = ch + 1'b1;
    col_next = col;
    row_next = row;
    if (ch == CHANNELS - 1) begin
      ch_next = '0;
      if (col == PADDED_WIDTH - 1) begin
        col_next = '0;
        // Wrap to the top left corner after the last word of the frame
        if (row == PADDED_HEIGHT - 1) begin
          row_next = '0;
        end else begin
          row_next = row + 1'b1;
        end
      end else begin
        col_next = col + 1'b1;
      end
    end
    next_in_image = (row_next >= PAD) && (row_next < PAD + IMG_HEIGHT) &&
                    (col_next >= PAD) && (col_next < PAD + IMG_WIDTH);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      row   <= '0;
      col   <= '0;
      ch    <= '0;
      state <= (PAD == 0) ? PAD_IMAGE : PAD_BORDER;
    end else if (out_fire) begin
      row   <= row_next;
      col   <= col_next;
      ch    <= ch_next;
      state <= next_in_image ? PAD_IMAGE : PAD_BORDER;
    end
  end

  // Image words pass straight through, border words come from the register
  always_comb begin
    if (state == PAD_IMAGE) begin
      pad_data  = pix_data;
      pad_valid = pix_valid;
      pix_ready = pad_ready;
    end else begin
      pad_data  = pad_value;
      pad_valid = 1'b1;
      pix_ready = 1'b0;
    end
  end

endmodule

// ==== verilog/window_line_buffer.sv ====
module window_line_buffer
  import window_geom_pkg::*;
#(
  parameter int DATA_WIDTH    = 16,
  parameter int PADDED_WIDTH  = 7,
  parameter int PADDED_HEIGHT = 6,
  parameter int CHANNELS      = 2,
  parameter int KERNEL_WIDTH  = 3,
  parameter int KERNEL_HEIGHT = 3
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [DATA_WIDTH-1:0]  pad_data,
  input  logic                   pad_valid,
  output logic                   pad_ready,
  output logic [DATA_WIDTH-1:0]  buf_data [KERNEL_HEIGHT*KERNEL_WIDTH],
  output logic [COORD_WIDTH-1:0] buf_x,
  output logic [COORD_WIDTH-1:0] buf_y,
  output logic [COORD_WIDTH-1:0] buf_c,
  output logic                   buf_valid,
  input  logic                   buf_ready
);

  localparam int LINE_WIDTH = PADDED_WIDTH * CHANNELS;
  localparam int BUF_SIZE = LINE_WIDTH * (KERNEL_HEIGHT - 1) +
                            (KERNEL_WIDTH - 1) * CHANNELS + 1;
  localparam int CX_WIDTH = $clog2(LINE_WIDTH + 1);
  localparam int X_LAST = PADDED_WIDTH - KERNEL_WIDTH;
  localparam int Y_LAST = PADDED_HEIGHT - KERNEL_HEIGHT;

  typedef enum logic [1:0] {
    FILL,
    PIPELINE,
    DRAIN
  } line_mode_e;

  line_mode_e mode;

  // Index 0 holds the oldest word, which is the origin of the current window
  logic [DATA_WIDTH-1:0] shift_reg [BUF_SIZE];

  // Input position counts words within a padded line, channel included
  logic [CX_WIDTH-1:0]    in_cx;
  logic [COORD_WIDTH-1:0] in_y;
  logic in_fire;
  logic out_fire;
  logic fill_done;
  logic in_last;
  logic out_last;

  assign in_fire  = pad_valid && pad_ready;
  assign out_fire = buf_valid && buf_ready;

  assign fill_done = (in_y == KERNEL_HEIGHT - 1) && (in_cx == (KERNEL_WIDTH - 1) * CHANNELS);
  assign in_last   = (in_y == PADDED_HEIGHT - 1) && (in_cx == LINE_WIDTH - 1);
  assign out_last  = (buf_y == Y_LAST) && (buf_x == X_LAST) && (buf_c == CHANNELS - 1);

  always_ff @(posedge clk) begin
    if (in_fire) begin
      for (int k = 0; k < BUF_SIZE - 1; k++) begin
        shift_reg[k] <= shift_reg[k+1];
      end
      shift_reg[BUF_SIZE-1] <= pad_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mode  <= FILL;
      in_cx <= '0;
      in_y  <= '0;
      buf_x <= '0;
      buf_y <= '0;
      buf_c <= '0;
    end else begin
      if (in_fire) begin
        if (in_cx == LINE_WIDTH - 1) begin
          in_cx <= '0;
          in_y  <= in_y + 1'b1;
        end else begin
          in_cx <= in_cx + 1'b1;
        end
        if (fill_done) begin
          mode <= PIPELINE;
        end
        // The final input word leaves exactly one window still to present
        if (in_last) begin
          mode  <= DRAIN;
          in_cx <= '0;
          in_y  <= '0;
        end
      end

      if (out_fire) begin
        if (buf_c == CHANNELS - 1) begin
          buf_c <= '0;
          if (buf_x == PADDED_WIDTH - 1) begin
            buf_x <= '0;
            buf_y <= buf_y + 1'b1;
          end else begin
            buf_x <= buf_x + 1'b1;
          end
        end else begin
          buf_c <= buf_c + 1'b1;
        end
        if (out_last) begin
          mode  <= FILL;
          buf_x <= '0;
          buf_y <= '0;
          buf_c <= '0;
        end
      end
    end
  end

  // In PIPELINE each output transfer goes together with one input word
  always_comb begin
    case (mode)
      PIPELINE: begin
        buf_valid = pad_valid;
        pad_ready = buf_ready;
      end
      DRAIN: begin
        buf_valid = 1'b1;
        pad_ready = 1'b0;
      end
      default: begin
        buf_valid = 1'b0;
        pad_ready = 1'b1;
      end
    endcase
  end

  // Row j of the kernel sits j lines after the origin, column i sits i pixels after it
  for (genvar j = 0; j < KERNEL_HEIGHT; j++) begin : g_row
    for (genvar i = 0; i < KERNEL_WIDTH; i++) begin : g_col
      assign buf_data[j*KERNEL_WIDTH+i] = shift_reg[j*LINE_WIDTH+i*CHANNELS];
    end
  end

endmodule

// ==== verilog/window_stride_filter.sv ====
module window_stride_filter
  import window_geom_pkg::*;
#(
  parameter int DATA_WIDTH    = 16,
  parameter int PADDED_WIDTH  = 7,
  parameter int PADDED_HEIGHT = 6,
  parameter int CHANNELS      = 2,
  parameter int KERNEL_WIDTH  = 3,
  parameter int KERNEL_HEIGHT = 3,
  parameter int STRIDE_WIDTH  = 4
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [DATA_WIDTH-1:0]   buf_data [KERNEL_HEIGHT*KERNEL_WIDTH],
  input  logic [COORD_WIDTH-1:0]  buf_x,
  input  logic [COORD_WIDTH-1:0]  buf_y,
  input  logic [COORD_WIDTH-1:0]  buf_c,
  input  logic                    buf_valid,
  output logic                    buf_ready,
  output logic [DATA_WIDTH-1:0]   win_data [KERNEL_HEIGHT*KERNEL_WIDTH],
  output logic [COORD_WIDTH-1:0]  win_c,
  output logic                    win_valid,
  output logic                    win_last,
  input  logic                    win_ready,
  input  logic [STRIDE_WIDTH-1:0] stride
);

  localparam int X_LIMIT = PADDED_WIDTH - KERNEL_WIDTH;
  localparam int Y_LIMIT = PADDED_HEIGHT - KERNEL_HEIGHT;

  // Distance of the current origin from the previous grid point
  logic [STRIDE_WIDTH-1:0] phase_x, phase_y;
  logic [COORD_WIDTH-1:0]  last_x, last_y;
  logic [STRIDE_WIDTH-1:0] calc_stride;
  logic in_range;
  logic on_grid;
  logic emit;
  logic buf_fire;
  logic origin_step;
  logic frame_end;

  assign in_range = (buf_x <= X_LIMIT) && (buf_y <= Y_LIMIT);
  assign on_grid  = (phase_x == '0) && (phase_y == '0);
  assign emit     = in_range && on_grid;

  assign buf_fire    = buf_valid && buf_ready;
  assign origin_step = buf_fire && (buf_c == CHANNELS - 1);
  assign frame_end   = origin_step && (buf_x == X_LIMIT) && (buf_y == Y_LIMIT);

  always_ff @(posedge clk) begin
    if (rst || frame_end) begin
      phase_x <= '0;
      phase_y <= '0;
    end else if (origin_step) begin
      if (buf_x == PADDED_WIDTH - 1) begin
        phase_x <= '0;
        phase_y <= (phase_y + 1'b1 == stride) ? '0 : phase_y + 1'b1;
      end else begin
        phase_x <= (phase_x + 1'b1 == stride) ? '0 : phase_x + 1'b1;
      end
    end
  end

  // Step up to the last grid point that still fits, one stride per cycle.
  // This finishes long before the line buffer has filled for the first window
  always_ff @(posedge clk) begin
    if (rst || frame_end || (stride != calc_stride)) begin
      calc_stride <= stride;
      last_x      <= '0;
      last_y      <= '0;
    end else begin
      if (last_x + stride <= X_LIMIT) begin
        last_x <= last_x + stride;
      end
      if (last_y + stride <= Y_LIMIT) begin
        last_y <= last_y + stride;
      end
    end
  end

  // Dropped windows are consumed here without reaching the output
  assign win_valid = buf_valid && emit;
  assign buf_ready = win_ready || !emit;
  assign win_data  = buf_data;
  assign win_c     = buf_c;
  assign win_last  = emit && (buf_x == last_x) && (buf_y == last_y) &&
                     (buf_c == CHANNELS - 1);

endmodule

// ==== verilog/sliding_window_top.sv ====
module sliding_window_top
  import window_geom_pkg::*, window_cfg_pkg::*;
#(
  parameter int DATA_WIDTH    = DEF_DATA_WIDTH,
  parameter int IMG_WIDTH     = DEF_IMG_WIDTH,
  parameter int IMG_HEIGHT    = DEF_IMG_HEIGHT,
  parameter int CHANNELS      = DEF_CHANNELS,
  parameter int KERNEL_WIDTH  = DEF_KERNEL_WIDTH,
  parameter int KERNEL_HEIGHT = DEF_KERNEL_HEIGHT,
  parameter int PAD           = DEF_PAD,
  parameter int MAX_STRIDE    = DEF_MAX_STRIDE
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   cfg_wr,
  input  cfg_addr_e              cfg_addr,
  input  logic [DATA_WIDTH-1:0]  cfg_wdata,
  output logic [DATA_WIDTH-1:0]  cfg_rdata,
  input  logic [DATA_WIDTH-1:0]  pix_data,
  input  logic                   pix_valid,
  output logic                   pix_ready,
  output logic [DATA_WIDTH-1:0]  win_data [KERNEL_HEIGHT*KERNEL_WIDTH],
  output logic [COORD_WIDTH-1:0] win_c,
  output logic                   win_valid,
  output logic                   win_last,
  input  logic                   win_ready
);

  localparam int PADDED_WIDTH = IMG_WIDTH + 2 * PAD;
  localparam int PADDED_HEIGHT = IMG_HEIGHT + 2 * PAD;

  logic [STRIDE_WIDTH-1:0] stride;
  logic [DATA_WIDTH-1:0]   pad_value;
  logic [DATA_WIDTH-1:0]   pad_data;
  logic                    pad_valid;
  logic                    pad_ready;
  logic [DATA_WIDTH-1:0]   buf_data [KERNEL_HEIGHT*KERNEL_WIDTH];
  logic [COORD_WIDTH-1:0]  buf_x;
  logic [COORD_WIDTH-1:0]  buf_y;
  logic [COORD_WIDTH-1:0]  buf_c;
  logic                    buf_valid;
  logic                    buf_ready;

  window_cfg_regs #(
    .DATA_WIDTH(DATA_WIDTH),
    .MAX_STRIDE(MAX_STRIDE)
  ) u_cfg_regs (
    .clk      (clk),
    .rst      (rst),
    .cfg_wr   (cfg_wr),
    .cfg_addr (cfg_addr),
    .cfg_wdata(cfg_wdata),
    .cfg_rdata(cfg_rdata),
    .stride   (stride),
    .pad_value(pad_value)
  );

  window_padder #(
    .DATA_WIDTH(DATA_WIDTH),
    .IMG_WIDTH (IMG_WIDTH),
    .IMG_HEIGHT(IMG_HEIGHT),
    .CHANNELS  (CHANNELS),
    .PAD       (PAD)
  ) u_padder (
    .clk      (clk),
    .rst      (rst),
    .pix_data (pix_data),
    .pix_valid(pix_valid),
    .pix_ready(pix_ready),
    .pad_data (pad_data),
    .pad_valid(pad_valid),
    .pad_ready(pad_ready),
    .pad_value(pad_value)
  );

  window_line_buffer #(
    .DATA_WIDTH   (DATA_WIDTH),
    .PADDED_WIDTH (PADDED_WIDTH),
    .PADDED_HEIGHT(PADDED_HEIGHT),
    .CHANNELS     (CHANNELS),
    .KERNEL_WIDTH (KERNEL_WIDTH),
    .KERNEL_HEIGHT(KERNEL_HEIGHT)
  ) u_line_buffer (
    .clk      (clk),
    .rst      (rst),
    .pad_data (pad_data),
    .pad_valid(pad_valid),
    .pad_ready(pad_ready),
    .buf_data (buf_data),
    .buf_x    (buf_x),
    .buf_y    (buf_y),
    .buf_c    (buf_c),
    .buf_valid(buf_valid),
    .buf_ready(buf_ready)
  );

  window_stride_filter #(
    .DATA_WIDTH   (DATA_WIDTH),
    .PADDED_WIDTH (PADDED_WIDTH),
    .PADDED_HEIGHT(PADDED_HEIGHT),
    .CHANNELS     (CHANNELS),
    .KERNEL_WIDTH (KERNEL_WIDTH),
    .KERNEL_HEIGHT(KERNEL_HEIGHT),
    .STRIDE_WIDTH (STRIDE_WIDTH)
  ) u_stride_filter (
    .clk      (clk),
    .rst      (rst),
    .buf_data (buf_data),
    .buf_x    (buf_x),
    .buf_y    (buf_y),
    .buf_c    (buf_c),
    .buf_valid(buf_valid),
    .buf_ready(buf_ready),
    .win_data (win_data),
    .win_c    (win_c),
    .win_valid(win_valid),
    .win_last (win_last),
    .win_ready(win_ready),
    .stride   (stride)
  );

endmodule

// ==== bench/sliding_window_tb.sv ====
module sliding_window_tb
  import window_geom_pkg::*, window_cfg_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DW = DEF_DATA_WIDTH;
  localparam int CH = DEF_CHANNELS;
  localparam int KW = DEF_KERNEL_WIDTH;
  localparam int KH = DEF_KERNEL_HEIGHT;
  localparam int KSIZE = KW * KH;
  localparam int PW = DEF_IMG_WIDTH + 2 * DEF_PAD;
  localparam int PH = DEF_IMG_HEIGHT + 2 * DEF_PAD;
  localparam int X_LIMIT = PW - KW;
  localparam int Y_LIMIT = PH - KH;
  localparam int IMG_WORDS = DEF_IMG_WIDTH * DEF_IMG_HEIGHT * CH;
  // Border words in raster order before the first image word of a frame
  localparam int LEAD_WORDS = (DEF_PAD * PW + DEF_PAD) * CH;
  localparam int TIMEOUT = 4000;
  localparam logic [31:0] SEED = 32'hbf2ce526;

  logic                   clk = 1'b0;
  logic                   rst = 1'b1;
  logic                   cfg_wr = 1'b0;
  cfg_addr_e              cfg_addr = CFG_STRIDE;
  logic [DW-1:0]          cfg_wdata = '0;
  logic [DW-1:0]          cfg_rdata;
  logic [DW-1:0]          pix_data = '0;
  logic                   pix_valid = 1'b0;
  logic                   pix_ready;
  logic [DW-1:0]          win_data [KSIZE];
  logic [COORD_WIDTH-1:0] win_c;
  logic                   win_valid;
  logic                   win_last;
  logic                   win_ready = 1'b1;

  // Reference model state and the list of windows still expected
  logic [DW-1:0]          img [IMG_WORDS];
  logic [DW*KSIZE-1:0]    exp_win_q [$];
  logic [COORD_WIDTH-1:0] exp_c_q [$];
  bit                     exp_last_q [$];
  logic [DW*KSIZE-1:0]    win_packed;
  logic [DW*KSIZE-1:0]    held_win;
  logic [COORD_WIDTH-1:0] held_c;
  logic                   held_last;
  bit                     stall_prev = 1'b0;
  bit                     bp_on = 1'b0;
  bit                     gaps_on = 1'b0;
  logic [31:0]            pix_rng = SEED;
  logic [31:0]            bp_rng = ~SEED;
  int                     stride_now = RESET_STRIDE;
  logic [DW-1:0]          pad_now = DW'(RESET_PAD_VALUE);
  logic [DW-1:0]          lead_pad = DW'(RESET_PAD_VALUE);
  int                     errors = 0;
  int                     test_errors = 0;
  int                     tests_run = 0;
  int                     pix_taken = 0;
  int                     win_count = 0;
  int                     last_count = 0;
  int                     frame_windows = 0;

  sliding_window_top UUT (
    .clk      (clk),
    .rst      (rst),
    .cfg_wr   (cfg_wr),
    .cfg_addr (cfg_addr),
    .cfg_wdata(cfg_wdata),
    .cfg_rdata(cfg_rdata),
    .pix_data (pix_data),
    .pix_valid(pix_valid),
    .pix_ready(pix_ready),
    .win_data (win_data),
    .win_c    (win_c),
    .win_valid(win_valid),
    .win_last (win_last),
    .win_ready(win_ready)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  always_comb begin
    for (int k = 0; k < KSIZE; k++) begin
      win_packed[k*DW +: DW] = win_data[k];
    end
  end

  // Random stalls on the window output when back-pressure is enabled
  always @(negedge clk) begin
    bp_rng = lcg_next(bp_rng);
    win_ready = bp_on ? bp_rng[20] : 1'b1;
  end

  always @(posedge clk) begin
    if (rst) begin
      stall_prev = 1'b0;
    end else begin
      // A stalled window must still be there one cycle later, unchanged
      if (stall_prev) begin
        assert (win_valid && win_packed == held_win && win_c == held_c &&
                win_last == held_last)
        else begin
          $display("Window output changed or dropped while win_ready was low");
          errors++;
        end
      end
      if (pix_valid && pix_ready) begin
        pix_taken++;
      end
      if (win_valid && win_ready) begin
        check_window();
      end
      stall_prev = win_valid && !win_ready;
      held_win = win_packed;
      held_c = win_c;
      held_last = win_last;
    end
  end

  task automatic check_window();
    logic [DW*KSIZE-1:0]    exp_win;
    logic [COORD_WIDTH-1:0] exp_c;
    bit                     exp_last;
    win_count++;
    if (win_last) begin
      last_count++;
    end
    if (exp_win_q.size() == 0) begin
      $display("A window for channel %0d arrived when none was expected", win_c);
      errors++;
    end else begin
      exp_win = exp_win_q.pop_front();
      exp_c = exp_c_q.pop_front();
      exp_last = exp_last_q.pop_front();
      for (int k = 0; k < KSIZE; k++) begin
        assert (win_data[k] === exp_win[k*DW +: DW])
        else begin
          $display("FAIL win_data[%0d]: got %h expected %h", k, win_data[k],
                   exp_win[k*DW +: DW]);
          errors++;
        end
      end
      assert (win_c === exp_c)
      else begin
        $display("FAIL win_c: got %h expected %h", win_c, exp_c);
        errors++;
      end
      assert (win_last === exp_last)
      else begin
        $display("FAIL win_last: got %h expected %h", win_last, exp_last);
        errors++;
      end
    end
  endtask

  task automatic timeout_abort(input string what);
    $display("Timeout while waiting for %s", what);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic make_image();
    for (int i = 0; i < IMG_WORDS; i++) begin
      pix_rng = lcg_next(pix_rng);
      img[i] = pix_rng[31 -: DW];
    end
  endtask

  // The leading border goes out right after the previous frame, so it carries
  // the pad value that was set before this frame's register writes
  task automatic build_expected();
    logic [DW-1:0]       frame [PW*PH*CH];
    logic [DW*KSIZE-1:0] win;
    int                  idx;
    exp_win_q.delete();
    exp_c_q.delete();
    exp_last_q.delete();
    for (int y = 0; y < PH; y++) begin
      for (int x = 0; x < PW; x++) begin
        for (int c = 0; c < CH; c++) begin
          idx = (y * PW + x) * CH + c;
          if (idx < LEAD_WORDS) begin
            frame[idx] = lead_pad;
          end else if (y < DEF_PAD || y >= PH - DEF_PAD || x < DEF_PAD || x >= PW - DEF_PAD) begin
            frame[idx] = pad_now;
          end else begin
            frame[idx] = img[((y - DEF_PAD) * DEF_IMG_WIDTH + x - DEF_PAD) * CH + c];
          end
        end
      end
    end
    for (int oy = 0; oy <= Y_LIMIT; oy += stride_now) begin
      for (int ox = 0; ox <= X_LIMIT; ox += stride_now) begin
        for (int c = 0; c < CH; c++) begin
          for (int j = 0; j < KH; j++) begin
            for (int i = 0; i < KW; i++) begin
              win[(j*KW+i)*DW +: DW] = frame[((oy + j) * PW + ox + i) * CH + c];
            end
          end
          exp_win_q.push_back(win);
          exp_c_q.push_back(COORD_WIDTH'(c));
          exp_last_q.push_back((oy + stride_now > Y_LIMIT) && (ox + stride_now > X_LIMIT) &&
                               (c == CH - 1));
        end
      end
    end
    frame_windows = exp_win_q.size();
    win_count = 0;
    last_count = 0;
  endtask

  task automatic send_image(input int stop_after);
    int taken;
    int waited;
    for (int i = 0; i < stop_after; i++) begin
      pix_rng = lcg_next(pix_rng);
      if (gaps_on && pix_rng[9:8] == 2'b00) begin
        pix_valid = 1'b0;
        repeat (pix_rng[3:2] + 1) @(negedge clk);
      end
      pix_data = img[i];
      pix_valid = 1'b1;
      taken = pix_taken;
      waited = 0;
      while (pix_taken == taken) begin
        @(negedge clk);
        waited++;
        if (waited > TIMEOUT) begin
          timeout_abort("an input word to be accepted");
        end
      end
    end
    pix_valid = 1'b0;
  endtask

  task automatic wait_pix_ready();
    int waited = 0;
    while (!pix_ready) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        timeout_abort("pix_ready after the top border");
      end
    end
  endtask

  task automatic finish_frame();
    int waited = 0;
    while (exp_win_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        timeout_abort("the remaining windows of the frame");
      end
    end
    // A repeated or extra window would show up while the next top border fills
    wait_pix_ready();
    assert (win_count == frame_windows)
    else begin
      $display("Frame gave %0d windows instead of %0d", win_count, frame_windows);
      errors++;
    end
    assert (last_count == 1)
    else begin
      $display("win_last was high on %0d windows of one frame", last_count);
      errors++;
    end
    lead_pad = pad_now;
  endtask

  task automatic run_frame();
    make_image();
    build_expected();
    send_image(IMG_WORDS);
    finish_frame();
  endtask

  task automatic cfg_write(input cfg_addr_e addr, input logic [DW-1:0] data);
    cfg_wr = 1'b1;
    cfg_addr = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_wr = 1'b0;
    // Stride writes saturate into 1 to MAX_STRIDE
    if (addr == CFG_STRIDE) begin
      if (data == 0) begin
        stride_now = 1;
      end else if (data > DEF_MAX_STRIDE) begin
        stride_now = DEF_MAX_STRIDE;
      end else begin
        stride_now = data;
      end
    end else begin
      pad_now = data;
    end
  endtask

  task automatic cfg_expect(input cfg_addr_e addr, input logic [DW-1:0] expected);
    logic [DW-1:0] got;
    cfg_addr = addr;
    @(posedge clk);
    got = cfg_rdata;
    @(negedge clk);
    assert (got === expected)
    else begin
      $display("FAIL cfg_rdata: got %h expected %h", got, expected);
      errors++;
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    pix_valid = 1'b0;
    cfg_wr = 1'b0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    exp_win_q.delete();
    exp_c_q.delete();
    exp_last_q.delete();
    stride_now = RESET_STRIDE;
    pad_now = DW'(RESET_PAD_VALUE);
    lead_pad = pad_now;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_errors) begin
      $display("Test %0d, %s: ok", tests_run, name);
    end else begin
      $display("Test %0d, %s: %0d errors", tests_run, name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  initial begin
    apply_reset();
    wait_pix_ready();

    run_frame();
    end_test("stride 1 without back-pressure");

    cfg_write(CFG_STRIDE, DW'(2));
    cfg_write(CFG_PAD_VALUE, DW'(16'h00a5));
    cfg_expect(CFG_STRIDE, DW'(2));
    cfg_expect(CFG_PAD_VALUE, DW'(16'h00a5));
    run_frame();
    // Second frame has A5 on every border word, the top one included
    run_frame();
    end_test("stride 2 with pad value a5");

    bp_on = 1'b1;
    gaps_on = 1'b1;
    run_frame();
    run_frame();
    end_test("random back-pressure and input gaps");

    cfg_write(CFG_STRIDE, DW'(1));
    run_frame();
    cfg_write(CFG_STRIDE, DW'(3));
    run_frame();
    end_test("last-window marker for stride 1 and 3");

    cfg_write(CFG_STRIDE, DW'(0));
    cfg_expect(CFG_STRIDE, DW'(1));
    run_frame();
    cfg_write(CFG_STRIDE, DW'(9));
    cfg_expect(CFG_STRIDE, DW'(DEF_MAX_STRIDE));
    run_frame();
    end_test("stride saturation");

    make_image();
    build_expected();
    send_image(IMG_WORDS / 2);
    apply_reset();
    repeat (4) begin
      @(negedge clk);
      assert (!win_valid)
      else begin
        $display("FAIL win_valid: got %h expected %h", win_valid, 1'b0);
        errors++;
      end
    end
    cfg_expect(CFG_STRIDE, DW'(RESET_STRIDE));
    cfg_expect(CFG_PAD_VALUE, DW'(RESET_PAD_VALUE));
    wait_pix_ready();
    run_frame();
    end_test("reset in mid-frame");

    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
verilog/window_geom_pkg.sv
verilog/window_cfg_pkg.sv
verilog/window_cfg_regs.sv
verilog/window_padder.sv
verilog/window_line_buffer.sv
verilog/window_stride_filter.sv
verilog/sliding_window_top.sv
bench/sliding_window_tb.sv
